//--- Bender.yml
package:
  name: cplx_alu

sources:
  - include_dirs:
      - logic
    files:
      - logic/cplx_pkg.sv
      - logic/dsp_slice.sv
      - logic/inst_decoder.sv
      - logic/complex_alu.sv
      - logic/cplx_apb_regs.sv
      - logic/cplx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/cplx_tb.sv

//--- logic/complex_alu.sv
`include "cplx_consts.svh"

module complex_alu (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       valid_i,
	input  cplx_pkg::slice_mode_e      mode_i,
	input  logic                       re_add_i,
	input  logic                       im_swap_i,
	input  logic [2*`CPLX_DATA_W-1:0]  din_1_i, // {ar, ai}
	input  logic [2*`CPLX_DATA_W-1:0]  din_2_i, // {br, bi}
	output logic                       valid_o,
	output logic [2*`CPLX_RES_W-1:0]   dout_o   // {re, im}
);
	import cplx_pkg::*;

	localparam int DW = `CPLX_DATA_W;

	logic [DW-1:0] ar, ai, br, bi;
	logic [`CPLX_A_W-1:0] a_1, a_2, a_3, a_4;
	logic [`CPLX_B_W-1:0] b_1, b_2, b_3, b_4;
	logic [`CPLX_C_W-1:0] c_1, c_3;
	logic [`CPLX_P_W-1:0] p_1, p_2, p_3, p_4;
	logic                 is_add;

	logic [1:0] re_add_d, im_swap_d; // flags follow the slices
	logic [2:0] valid_d;
	logic [`CPLX_P_W-1:0] re_full, im_full;
	logic [`CPLX_RES_W-1:0] re_q, im_q;

	assign {ar, ai} = din_1_i;
	assign {br, bi} = din_2_i;
	assign is_add   = (mode_i == MODE_ADD) || (mode_i == MODE_SUB);

	////////////////////
	// operand routing
	always_comb begin
		a_1 = '0;
		a_2 = '0;
		a_3 = '0;
		a_4 = '0;
		b_1 = '0;
		b_2 = '0;
		b_3 = '0;
		b_4 = '0;
		c_1 = '0;
		c_3 = '0;
		if (is_add) begin
			c_1 = {{(`CPLX_C_W-DW){ar[DW-1]}}, ar}; // real part on core_1
			a_1 = {{(`CPLX_A_W-DW){br[DW-1]}}, br};
			c_3 = {{(`CPLX_C_W-DW){ai[DW-1]}}, ai}; // imag part on core_3
			a_3 = {{(`CPLX_A_W-DW){bi[DW-1]}}, bi};
		end else begin
			a_1 = {{(`CPLX_A_W-DW){ar[DW-1]}}, ar}; // ar*br
			b_1 = {{(`CPLX_B_W-DW){br[DW-1]}}, br};
			a_2 = {{(`CPLX_A_W-DW){ai[DW-1]}}, ai}; // ai*bi
			b_2 = {{(`CPLX_B_W-DW){bi[DW-1]}}, bi};
			a_3 = {{(`CPLX_A_W-DW){ar[DW-1]}}, ar}; // ar*bi
			b_3 = {{(`CPLX_B_W-DW){bi[DW-1]}}, bi};
			a_4 = {{(`CPLX_A_W-DW){ai[DW-1]}}, ai}; // ai*br
			b_4 = {{(`CPLX_B_W-DW){br[DW-1]}}, br};
		end
	end

	dsp_slice core_1 (.clk(clk), .rst_i(rst_i), .a_i(a_1), .b_i(b_1), .c_i(c_1),
		.mode_i(mode_i), .ce_i(valid_i), .p_o(p_1));
	dsp_slice core_2 (.clk(clk), .rst_i(rst_i), .a_i(a_2), .b_i(b_2), .c_i('0),
		.mode_i(mode_i), .ce_i(valid_i), .p_o(p_2)); // no c operand here
	dsp_slice core_3 (.clk(clk), .rst_i(rst_i), .a_i(a_3), .b_i(b_3), .c_i(c_3),
		.mode_i(mode_i), .ce_i(valid_i), .p_o(p_3));
	dsp_slice core_4 (.clk(clk), .rst_i(rst_i), .a_i(a_4), .b_i(b_4), .c_i('0),
		.mode_i(mode_i), .ce_i(valid_i), .p_o(p_4));

	////////////////////
	// combine stage
	assign re_full = re_add_d[1]  ? p_1 + p_2 : p_1 - p_2;
	assign im_full = im_swap_d[1] ? p_4 - p_3 : p_3 + p_4;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_d   <= '0;
			re_add_d  <= '0;
			im_swap_d <= '0;
		end else begin
			valid_d   <= {valid_d[1:0], valid_i};
			re_add_d  <= {re_add_d[0], re_add_i};
			im_swap_d <= {im_swap_d[0], im_swap_i};
		end
	end

	always_ff @(posedge clk) begin
		if (valid_d[1]) begin // P regs hold this op
			re_q <= re_full[`CPLX_RES_W-1:0];
			im_q <= im_full[`CPLX_RES_W-1:0];
		end
	end

	assign valid_o = valid_d[2];
	assign dout_o  = {re_q, im_q};

	ap_latency: assert property (@(posedge clk) disable iff (rst_i)
		valid_o == $past(valid_i, `CPLX_LAT));

endmodule

//--- logic/cplx_apb_regs.sv
`include "cplx_consts.svh"

module cplx_apb_regs (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic [`APB_ADDR_W-1:0]    paddr_i,
	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  logic [31:0]               pwdata_i,
	output logic [31:0]               prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o,
	input  logic                      legal_i,
	output logic [`CPLX_OP_W-1:0]     opcode_o,
	output logic                      issue_o,
	output logic [2*`CPLX_DATA_W-1:0] din_1_o,
	output logic [2*`CPLX_DATA_W-1:0] din_2_o,
	input  logic                      res_valid_i,
	input  logic [2*`CPLX_RES_W-1:0]  res_i
);
	localparam int CNT_W = 3; // few cmds fit in the pipe

	logic access, wr, rd;
	logic hit_opa, hit_opb, hit_cmd, hit_sts, hit_re, hit_im, mapped;
	logic launch, busy;
	logic [CNT_W-1:0] inflight_q;
	logic [2*`CPLX_DATA_W-1:0] opa_q, opb_q;
	logic [`CPLX_RES_W-1:0] res_re_q, res_im_q;

	////////////////////
	// address decode
	assign access  = psel_i & penable_i;
	assign wr      = access & pwrite_i;
	assign rd      = access & ~pwrite_i;
	assign hit_opa = (paddr_i == `REG_OPA);
	assign hit_opb = (paddr_i == `REG_OPB);
	assign hit_cmd = (paddr_i == `REG_CMD);
	assign hit_sts = (paddr_i == `REG_STATUS);
	assign hit_re  = (paddr_i == `REG_RES_RE);
	assign hit_im  = (paddr_i == `REG_RES_IM);
	assign mapped  = hit_opa | hit_opb | hit_cmd | hit_sts | hit_re | hit_im;

	assign busy      = |inflight_q;
	assign pready_o  = ~(rd & (hit_re | hit_im) & busy); // stall result reads
	assign issue_o   = wr & hit_cmd; // writes never wait
	assign opcode_o  = pwdata_i[`CPLX_OP_W-1:0];
	assign launch    = issue_o & legal_i;
	assign pslverr_o = access & pready_o & (~mapped | (issue_o & ~legal_i));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			opa_q <= '0;
			opb_q <= '0;
		end else begin
			if (wr & hit_opa)
				opa_q <= pwdata_i;
			if (wr & hit_opb)
				opb_q <= pwdata_i;
		end
	end

	////////////////////
	// in-flight count and capture
	always_ff @(posedge clk) begin
		if (rst_i)
			inflight_q <= '0;
		else if (launch & ~res_valid_i)
			inflight_q <= inflight_q + 1'b1;
		else if (~launch & res_valid_i)
			inflight_q <= inflight_q - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			res_re_q <= '0;
			res_im_q <= '0;
		end else if (res_valid_i) begin
			{res_re_q, res_im_q} <= res_i; // newest wins
		end
	end

	always_comb begin
		prdata_o = '0;
		if (hit_opa)
			prdata_o = opa_q;
		else if (hit_opb)
			prdata_o = opb_q;
		else if (hit_sts)
			prdata_o = {31'b0, busy};
		else if (hit_re)
			prdata_o = res_re_q;
		else if (hit_im)
			prdata_o = res_im_q;
	end

	assign din_1_o = opa_q;
	assign din_2_o = opb_q;

	ap_no_underflow: assert property (@(posedge clk) disable iff (rst_i)
		res_valid_i |-> inflight_q != '0);

endmodule

//--- logic/cplx_consts.svh
`ifndef CPLX_CONSTS_SVH
`define CPLX_CONSTS_SVH

////////////////////
// datapath widths
`define CPLX_DATA_W 16 // one real or imag part
`define CPLX_A_W    30 // slice port a
`define CPLX_B_W    18 // slice port b
`define CPLX_C_W    48 // slice port c
`define CPLX_P_W    48 // slice accumulator
`define CPLX_RES_W  32 // each result part
`define CPLX_OP_W   3  // opcode field
`define CPLX_LAT    3  // issue to result valid

////////////////////
// apb register map
`define APB_ADDR_W  8
`define REG_OPA     8'h00 // {ar, ai}
`define REG_OPB     8'h04 // {br, bi}
`define REG_CMD     8'h08 // write launches
`define REG_STATUS  8'h0C // bit 0 busy
`define REG_RES_RE  8'h10
`define REG_RES_IM  8'h14

`endif

//--- logic/cplx_pkg.sv
`include "cplx_consts.svh"

package cplx_pkg;

	////////////////////
	// software opcodes, 5..7 illegal
	typedef enum logic [`CPLX_OP_W-1:0] {
		CMUL  = 3'd0, // a * b
		CMULC = 3'd1, // a * conj(b)
		CADD  = 3'd2, // a + b
		CSUB  = 3'd3, // a - b
		CMAC  = 3'd4  // acc += a * b
	} cplx_op_e;

	////////////////////
	// per-slice alu mode
	typedef enum logic [1:0] {
		MODE_MUL  = 2'd0, // p = a*b
		MODE_MACC = 2'd1, // p = p + a*b
		MODE_ADD  = 2'd2, // p = c + a
		MODE_SUB  = 2'd3  // p = c - a
	} slice_mode_e;

endpackage

//--- logic/cplx_top.sv
`include "cplx_consts.svh"

module cplx_top (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [`APB_ADDR_W-1:0] paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  logic [31:0]            pwdata_i,
	output logic [31:0]            prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o
);
	import cplx_pkg::*;

	logic [`CPLX_OP_W-1:0] opcode; // regs -> decoder
	logic issue, legal;
	logic dec_valid, re_add, im_swap;
	slice_mode_e mode;
	logic [2*`CPLX_DATA_W-1:0] din_1, din_2;
	logic res_valid;
	logic [2*`CPLX_RES_W-1:0] res; // {re, im}

	cplx_apb_regs u_regs (.clk(clk), .rst_i(rst_i), .paddr_i(paddr_i), .psel_i(psel_i),
		.penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.legal_i(legal), .opcode_o(opcode), .issue_o(issue), .din_1_o(din_1),
		.din_2_o(din_2), .res_valid_i(res_valid), .res_i(res));

	inst_decoder u_dec (.clk(clk), .rst_i(rst_i), .opcode_i(opcode), .issue_i(issue),
		.legal_o(legal), .valid_o(dec_valid), .mode_o(mode), .re_add_o(re_add),
		.im_swap_o(im_swap));

	complex_alu u_alu (.clk(clk), .rst_i(rst_i), .valid_i(dec_valid), .mode_i(mode),
		.re_add_i(re_add), .im_swap_i(im_swap), .din_1_i(din_1), .din_2_i(din_2),
		.valid_o(res_valid), .dout_o(res));

endmodule

//--- logic/dsp_slice.sv
`include "cplx_consts.svh"

module dsp_slice (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic [`CPLX_A_W-1:0]     a_i,
	input  logic [`CPLX_B_W-1:0]     b_i,
	input  logic [`CPLX_C_W-1:0]     c_i,
	input  cplx_pkg::slice_mode_e    mode_i,
	input  logic                     ce_i,
	output logic [`CPLX_P_W-1:0]     p_o
);
	import cplx_pkg::*;

	logic [`CPLX_A_W-1:0] a_q; // input regs, like A2/B2/C
	logic [`CPLX_B_W-1:0] b_q;
	logic [`CPLX_C_W-1:0] c_q;
	slice_mode_e          mode_q;
	logic                 en_q; // op pending in P stage

	logic signed [`CPLX_A_W+`CPLX_B_W-1:0] prod; // 30x18 -> 48
	logic [`CPLX_P_W-1:0] a_ext;
	logic [`CPLX_P_W-1:0] p_d;
	logic [`CPLX_P_W-1:0] p_q;

	////////////////////
	// input register stage
	always_ff @(posedge clk) begin
		if (ce_i) begin
			a_q <= a_i;
			b_q <= b_i;
			c_q <= c_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			en_q   <= 1'b0;
			mode_q <= MODE_MUL;
		end else begin
			en_q <= ce_i;
			if (ce_i)
				mode_q <= mode_i;
		end
	end

	////////////////////
	// multiplier and alu
	assign prod  = $signed(a_q) * $signed(b_q);
	assign a_ext = {{(`CPLX_P_W-`CPLX_A_W){a_q[`CPLX_A_W-1]}}, a_q}; // sign extend

	always_comb begin
		case (mode_q)
			MODE_MUL:  p_d = prod;
			MODE_MACC: p_d = p_q + prod; // feedback from P
			MODE_ADD:  p_d = c_q + a_ext;
			default:   p_d = c_q - a_ext; // MODE_SUB
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			p_q <= '0;
		else if (en_q)
			p_q <= p_d; // holds while idle
	end

	assign p_o = p_q;

	ap_mode_known: assert property (@(posedge clk) disable iff (rst_i)
		ce_i |-> !$isunknown(mode_i));

endmodule

//--- logic/inst_decoder.sv
`include "cplx_consts.svh"

module inst_decoder (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [`CPLX_OP_W-1:0] opcode_i,
	input  logic                  issue_i,
	output logic                  legal_o,
	output logic                  valid_o,
	output cplx_pkg::slice_mode_e mode_o,
	output logic                  re_add_o,
	output logic                  im_swap_o
);
	import cplx_pkg::*;

	cplx_op_e    op;
	slice_mode_e mode_d;
	logic        re_add_d;
	logic        im_swap_d;
	logic        launch;

	assign op      = cplx_op_e'(opcode_i);
	assign legal_o = op inside {CMUL, CMULC, CADD, CSUB, CMAC}; // combinational to regs
	assign launch  = issue_i & legal_o;

	////////////////////
	// opcode to slice control
	always_comb begin
		mode_d    = MODE_MUL;
		re_add_d  = 1'b0;
		im_swap_d = 1'b0;
		case (op)
			CMULC: begin
				re_add_d  = 1'b1; // ar*br + ai*bi
				im_swap_d = 1'b1; // ai*br - ar*bi
			end
			CADD:    mode_d = MODE_ADD;
			CSUB:    mode_d = MODE_SUB;
			CMAC:    mode_d = MODE_MACC;
			default: mode_d = MODE_MUL; // CMUL
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o   <= 1'b0;
			mode_o    <= MODE_MUL;
			re_add_o  <= 1'b0;
			im_swap_o <= 1'b0;
		end else begin
			valid_o <= launch;
			if (launch) begin
				mode_o    <= mode_d;
				re_add_o  <= re_add_d;
				im_swap_o <= im_swap_d;
			end
		end
	end

endmodule

//--- sim.f
+incdir+logic
logic/cplx_pkg.sv
logic/dsp_slice.sv
logic/inst_decoder.sv
logic/complex_alu.sv
logic/cplx_apb_regs.sv
logic/cplx_top.sv
verification/cplx_tb.sv

//--- verification/cplx_tb.sv
`include "cplx_consts.svh"

module cplx_tb;
	import cplx_pkg::*;

	localparam int HALF    = 20; // 40 unit period
	localparam int SETTLE  = 10; // sample point after falling edge
	localparam int TIMEOUT = 50; // cycles per wait loop

	typedef struct packed {
		logic [2:0]  op;
		logic [31:0] opa; // {ar, ai}
		logic [31:0] opb; // {br, bi}
		logic        err; // pslverr expected on the cmd write
	} row_t;

	logic                   clk, rst;
	logic [`APB_ADDR_W-1:0] paddr;
	logic                   psel, penable, pwrite;
	logic [31:0]            pwdata, prdata;
	logic                   pready, pslverr;

	row_t               table_q[$];
	logic signed [47:0] p_m [4]; // model of the four P regs
	logic [31:0]        exp_re, exp_im;

	cplx_top uut (.clk(clk), .rst_i(rst), .paddr_i(paddr), .psel_i(psel),
		.penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr));

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	task automatic fail_stop();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check32(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			fail_stop();
		end
	endtask

	////////////////////
	// apb master
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int stalls);
		stalls = 0;
		@(negedge clk);
		psel    = 1'b1; // setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1; // access phase
		#SETTLE;
		while (!pready) begin
			stalls++;
			if (stalls > TIMEOUT) begin
				$display("timed out waiting for pready at address %h", addr);
				fail_stop();
			end
			@(negedge clk);
			#SETTLE;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk); // completed on the rising edge
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		int          st;
		apb_xfer(1'b1, addr, data, rd, err, st);
		check32("pslverr", {31'b0, err}, {31'b0, exp_err});
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic exp_err,
		output logic [31:0] data, output int stalls);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, data, err, stalls);
		check32("pslverr", {31'b0, err}, {31'b0, exp_err});
	endtask

	task automatic wait_idle();
		logic [31:0] sts;
		int          st;
		int          n;
		n = 0;
		read_reg(`REG_STATUS, 1'b0, sts, st);
		while (sts[0]) begin // busy bit
			n++;
			if (n > TIMEOUT) begin
				$display("busy bit never cleared");
				fail_stop();
			end
			read_reg(`REG_STATUS, 1'b0, sts, st);
		end
	endtask

	////////////////////
	// reference model
	function automatic logic signed [47:0] sx(input logic [15:0] v);
		return {{32{v[15]}}, v};
	endfunction

	task automatic model_apply(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
		logic signed [47:0] ar, ai, br, bi, re, im;
		if (op > CMAC)
			return; // illegal, nothing launches
		ar = sx(a[31:16]);
		ai = sx(a[15:0]);
		br = sx(b[31:16]);
		bi = sx(b[15:0]);
		case (op)
			CMAC: begin
				p_m[0] = p_m[0] + ar * br; // accumulate on old P
				p_m[1] = p_m[1] + ai * bi;
				p_m[2] = p_m[2] + ar * bi;
				p_m[3] = p_m[3] + ai * br;
			end
			CADD: begin
				p_m[0] = ar + br;
				p_m[1] = '0; // zero operands
				p_m[2] = ai + bi;
				p_m[3] = '0;
			end
			CSUB: begin
				p_m[0] = ar - br;
				p_m[1] = '0;
				p_m[2] = ai - bi;
				p_m[3] = '0;
			end
			default: begin // CMUL and CMULC
				p_m[0] = ar * br;
				p_m[1] = ai * bi;
				p_m[2] = ar * bi;
				p_m[3] = ai * br;
			end
		endcase
		re = (op == CMULC) ? p_m[0] + p_m[1] : p_m[0] - p_m[1];
		im = (op == CMULC) ? p_m[3] - p_m[2] : p_m[2] + p_m[3];
		exp_re = re[31:0]; // low 32 bits only
		exp_im = im[31:0];
	endtask

	function automatic row_t make_row(input logic [2:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic err);
		row_t r;
		r.op  = op;
		r.opa = a;
		r.opb = b;
		r.err = err;
		return r;
	endfunction

	task automatic run_row(input row_t r);
		logic [31:0] got;
		int          st;
		write_reg(`REG_OPA, r.opa, 1'b0);
		write_reg(`REG_OPB, r.opb, 1'b0);
		write_reg(`REG_CMD, {29'b0, r.op}, r.err);
		if (r.err) begin
			read_reg(`REG_STATUS, 1'b0, got, st);
			check32("busy", got, 32'h0); // nothing launched
		end else begin
			model_apply(r.op, r.opa, r.opb);
			wait_idle();
		end
		read_reg(`REG_RES_RE, 1'b0, got, st);
		check32("res_re", got, exp_re);
		read_reg(`REG_RES_IM, 1'b0, got, st);
		check32("res_im", got, exp_im);
	endtask

	////////////////////
	// main sequence
	initial begin
		logic [31:0] got;
		int          st;
		rst     = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		exp_re  = '0; // result regs clear on reset
		exp_im  = '0;
		foreach (p_m[i])
			p_m[i] = '0;
		void'($urandom(32'h435f));

		table_q.push_back(make_row(CMAC,  32'h0007_FFF9, 32'hFFFD_0002, 1'b0)); // acc from reset P
		table_q.push_back(make_row(CMUL,  32'h0003_0004, 32'h0005_FFFE, 1'b0));
		table_q.push_back(make_row(3'd5,  32'h0001_0001, 32'h0001_0001, 1'b1)); // illegal
		table_q.push_back(make_row(CMULC, 32'h0003_0004, 32'h0005_FFFE, 1'b0));
		table_q.push_back(make_row(CMUL,  32'h8000_8000, 32'h8000_7FFF, 1'b0)); // extremes
		table_q.push_back(make_row(CMULC, 32'h8000_7FFF, 32'h8000_8000, 1'b0));
		table_q.push_back(make_row(CADD,  32'h7FFF_8000, 32'h0001_FFFF, 1'b0));
		table_q.push_back(make_row(CSUB,  32'h8000_7FFF, 32'h0001_FFFF, 1'b0));
		table_q.push_back(make_row(3'd7,  32'h1111_2222, 32'h3333_4444, 1'b1));
		table_q.push_back(make_row(CMUL,  32'h0002_0001, 32'h0003_0004, 1'b0)); // mac chain
		table_q.push_back(make_row(CMAC,  32'h0001_FFFF, 32'h0002_0003, 1'b0));
		table_q.push_back(make_row(CMAC,  32'h8000_8000, 32'h8000_8000, 1'b0));
		table_q.push_back(make_row(3'd6,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1));
		repeat (6)
			table_q.push_back(make_row(3'($urandom_range(0, 4)), $urandom, $urandom, 1'b0));

		repeat (4) @(negedge clk);
		rst = 1'b0;
		#SETTLE;
		check32("pready", {31'b0, pready}, 32'h1); // idle bus after reset
		check32("pslverr", {31'b0, pslverr}, 32'h0);
		read_reg(`REG_STATUS, 1'b0, got, st);
		check32("busy", got, 32'h0);
		read_reg(`REG_RES_RE, 1'b0, got, st);
		check32("res_re", got, exp_re);
		read_reg(`REG_RES_IM, 1'b0, got, st);
		check32("res_im", got, exp_im);

		foreach (table_q[i])
			run_row(table_q[i]);

		write_reg(8'h18, 32'h0000_0001, 1'b1); // unmapped write
		read_reg(8'h20, 1'b1, got, st); // unmapped read
		read_reg(`REG_RES_RE, 1'b0, got, st);
		check32("res_re", got, exp_re);

		// two commands back to back, then a result read right away
		write_reg(`REG_OPA, 32'h1234_8765, 1'b0);
		write_reg(`REG_OPB, 32'h0F0F_F0F0, 1'b0);
		write_reg(`REG_CMD, {29'b0, CMUL}, 1'b0);
		model_apply(CMUL, 32'h1234_8765, 32'h0F0F_F0F0);
		write_reg(`REG_CMD, {29'b0, CMAC}, 1'b0);
		model_apply(CMAC, 32'h1234_8765, 32'h0F0F_F0F0);
		read_reg(`REG_RES_RE, 1'b0, got, st);
		assert (st > 0) else begin
			$display("result read was not stalled while commands were in flight");
			fail_stop();
		end
		check32("res_re", got, exp_re);
		read_reg(`REG_RES_IM, 1'b0, got, st);
		check32("res_im", got, exp_im);
		read_reg(`REG_STATUS, 1'b0, got, st);
		check32("busy", got, 32'h0);

		$display("All tests passed!");
		$finish;
	end

endmodule
